//--- rtl/mmu_pkg.sv
// widths assume 4 KiB pages, a 24-bit VA split 6/6/12, and a 1024-word table memory
package mmu_pkg;

	localparam int vaddr_bits = 24;
	localparam int paddr_bits = 32;
	localparam int vpn_bits = 12;
	localparam int ppn_bits = 20;
	localparam int level_bits = 6; // index bits per table level
	localparam int page_offset_bits = 12;

	localparam int tlb_sets = 16;
	localparam int tlb_index_bits = $clog2(tlb_sets);
	localparam int tlb_tag_bits = 8;

	localparam int pte_valid_bit = 0;
	localparam int pte_ppn_lsb = 10; // ppn in bits 29:10

	localparam int mem_words = 1024;

	typedef logic [vaddr_bits-1:0] vaddr_t;
	typedef logic [paddr_bits-1:0] paddr_t;
	typedef logic [vpn_bits-1:0] vpn_t;
	typedef logic [ppn_bits-1:0] ppn_t;
	typedef logic [63:0] pte_t;
	typedef logic [$clog2(mem_words)-1:0] word_addr_t;

	typedef enum logic [1:0] {
		tlb_idle,
		tlb_lookup,
		tlb_walk,
		tlb_respond
	} tlb_state_t;

	typedef enum logic [2:0] {
		pw_idle,
		pw_read_l1,
		pw_wait_l1,
		pw_read_l2,
		pw_wait_l2,
		pw_done
	} walk_state_t;

endpackage

//--- rtl/phys_mem.sv
// no reset and no init; contents are undefined until written
`timescale 1ns/1ps

module phys_mem import mmu_pkg::*; (
	input logic clk,
	input logic mem_en,
	input logic mem_we,
	input word_addr_t mem_addr,
	input pte_t mem_wdata,
	output pte_t mem_rdata
);

	pte_t ram [mem_words];

	always_ff @(posedge clk) begin
		if (mem_en) begin
			if (mem_we)
				ram[mem_addr] <= mem_wdata;
			else
				mem_rdata <= ram[mem_addr]; // one cycle read latency
		end
	end

endmodule

//--- rtl/mem_arbiter.sv
// walker only reads; a host read is allowed but its data is dropped
`timescale 1ns/1ps

module mem_arbiter import mmu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic w_valid,
	output logic w_ready,
	input word_addr_t w_addr,
	output logic w_rvalid,
	output pte_t w_rdata,
	input logic h_valid,
	output logic h_ready,
	input logic h_we,
	input word_addr_t h_addr,
	input pte_t h_wdata,
	output logic mem_en,
	output logic mem_we,
	output word_addr_t mem_addr,
	output pte_t mem_wdata,
	input pte_t mem_rdata
);

	logic prio_host; // host wins the next tie
	logic rd_pending;
	logic owner_w;

	always_comb begin
		w_ready = 1'b0;
		h_ready = 1'b0;
		if (!rd_pending) begin // locked while a read is in flight
			if (w_valid && h_valid) begin
				h_ready = prio_host;
				w_ready = !prio_host;
			end else begin
				w_ready = w_valid;
				h_ready = h_valid;
			end
		end
	end

	assign mem_en = w_ready || h_ready;
	assign mem_we = h_ready && h_we;
	assign mem_addr = h_ready ? h_addr : w_addr;
	assign mem_wdata = h_wdata;

	assign w_rvalid = rd_pending && owner_w;
	assign w_rdata = mem_rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			prio_host <= 1'b0;
			rd_pending <= 1'b0;
			owner_w <= 1'b0;
		end else begin
			rd_pending <= mem_en && !mem_we;
			if (mem_en) begin
				owner_w <= w_ready;
				prio_host <= w_ready; // turn passes to the other master
			end
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (reset) !(w_ready && h_ready));

endmodule

//--- rtl/page_walker.sv
// read-only master; tables must sit in word memory with the L2 base in the low PPN bits
`timescale 1ns/1ps

module page_walker import mmu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic walk_valid,
	output logic walk_ready,
	input vpn_t walk_vpn,
	output logic walk_done,
	output ppn_t walk_ppn,
	output logic walk_fault,
	input word_addr_t ptbr,
	output logic m_valid,
	input logic m_ready,
	output word_addr_t m_addr,
	input logic m_rvalid,
	input pte_t m_rdata
);

	walk_state_t state;
	vpn_t vpn_q;
	word_addr_t l2_base;
	logic [level_bits-1:0] l1_idx;
	logic [level_bits-1:0] l2_idx;
	logic pte_valid;

	assign l1_idx = vpn_q[vpn_bits-1 -: level_bits];
	assign l2_idx = vpn_q[level_bits-1:0];
	assign pte_valid = m_rdata[pte_valid_bit];

	assign walk_ready = (state == pw_idle);
	assign walk_done = (state == pw_done);
	assign m_valid = (state == pw_read_l1) || (state == pw_read_l2);
	assign m_addr = (state == pw_read_l2) ? l2_base + word_addr_t'(l2_idx)
		: ptbr + word_addr_t'(l1_idx);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pw_idle;
		end else begin
			case (state)
			pw_idle:
				if (walk_valid)
					state <= pw_read_l1;
			pw_read_l1:
				if (m_ready)
					state <= pw_wait_l1;
			pw_wait_l1:
				if (m_rvalid)
					state <= pte_valid ? pw_read_l2 : pw_done; // invalid l1 ends the walk
			pw_read_l2:
				if (m_ready)
					state <= pw_wait_l2;
			pw_wait_l2:
				if (m_rvalid)
					state <= pw_done;
			pw_done:
				state <= pw_idle;
			default:
				state <= pw_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (walk_valid && walk_ready)
			vpn_q <= walk_vpn;
		if (state == pw_wait_l1 && m_rvalid) begin
			walk_fault <= !pte_valid;
			l2_base <= m_rdata[pte_ppn_lsb +: $bits(word_addr_t)];
		end
		if (state == pw_wait_l2 && m_rvalid) begin
			walk_fault <= !pte_valid;
			walk_ppn <= m_rdata[pte_ppn_lsb +: ppn_bits];
		end
	end

	// read returns next cycle and nothing new is issued meanwhile
	a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
		m_valid && m_ready |=> !m_valid && m_rvalid);

endmodule

//--- rtl/tlb.sv
// one translation in flight; flush is ignored unless idle; faulting walks are never cached
`timescale 1ns/1ps

module tlb import mmu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input vaddr_t req_vaddr,
	output logic resp_valid,
	input logic resp_ready,
	output paddr_t resp_paddr,
	output logic resp_fault,
	input logic flush,
	output logic walk_valid,
	input logic walk_ready,
	output vpn_t walk_vpn,
	input logic walk_done,
	input ppn_t walk_ppn,
	input logic walk_fault
);

	tlb_state_t state;
	vaddr_t vaddr_q;
	vpn_t vpn_q;

	logic [tlb_tag_bits-1:0] tag_mem [2][tlb_sets];
	ppn_t ppn_mem [2][tlb_sets];
	logic [tlb_sets-1:0] valid_mem [2];
	logic [tlb_sets-1:0] lru_mem; // 1 = way 1 is least recently used

	logic [tlb_index_bits-1:0] set_idx;
	logic [tlb_tag_bits-1:0] tag_in;
	logic [page_offset_bits-1:0] offset;
	logic hit0;
	logic hit1;
	logic victim;

	assign vpn_q = vaddr_q[vaddr_bits-1:page_offset_bits];
	assign set_idx = vpn_q[tlb_index_bits-1:0];
	assign tag_in = vpn_q[vpn_bits-1 -: tlb_tag_bits];
	assign offset = vaddr_q[page_offset_bits-1:0];

	assign hit0 = valid_mem[0][set_idx] && (tag_mem[0][set_idx] == tag_in);
	assign hit1 = valid_mem[1][set_idx] && (tag_mem[1][set_idx] == tag_in);
	assign victim = lru_mem[set_idx];

	assign req_ready = (state == tlb_idle);
	assign resp_valid = (state == tlb_respond);
	assign walk_vpn = vpn_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tlb_idle;
			walk_valid <= 1'b0;
			lru_mem <= '0;
			valid_mem[0] <= '0;
			valid_mem[1] <= '0;
		end else begin
			case (state)
			tlb_idle: begin
				if (flush) begin
					valid_mem[0] <= '0;
					valid_mem[1] <= '0;
				end
				if (req_valid)
					state <= tlb_lookup;
			end
			tlb_lookup: begin
				if (hit0 || hit1) begin
					lru_mem[set_idx] <= ~hit1; // other way goes stale
					state <= tlb_respond;
				end else begin
					walk_valid <= 1'b1;
					state <= tlb_walk;
				end
			end
			tlb_walk: begin
				if (walk_valid && walk_ready)
					walk_valid <= 1'b0;
				if (walk_done) begin
					if (!walk_fault) begin
						valid_mem[victim][set_idx] <= 1'b1;
						lru_mem[set_idx] <= ~victim;
					end
					state <= tlb_respond;
				end
			end
			tlb_respond: begin
				if (resp_ready)
					state <= tlb_idle;
			end
			default: state <= tlb_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			vaddr_q <= req_vaddr;
		if (state == tlb_lookup && (hit0 || hit1)) begin
			resp_paddr <= {hit1 ? ppn_mem[1][set_idx] : ppn_mem[0][set_idx], offset};
			resp_fault <= 1'b0;
		end
		if (state == tlb_walk && walk_done) begin
			resp_paddr <= {walk_ppn, offset};
			resp_fault <= walk_fault;
			if (!walk_fault) begin // fill lru way
				tag_mem[victim][set_idx] <= tag_in;
				ppn_mem[victim][set_idx] <= walk_ppn;
			end
		end
	end

	a_resp_stable: assert property (@(posedge clk) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && !req_ready &&
			$stable(resp_paddr) && $stable(resp_fault));

endmodule

//--- rtl/mmu_top.sv
// host port is write-only and shares memory with the walker; ptbr must stay stable during walks
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic req_valid,
	output logic req_ready,
	input vaddr_t req_vaddr,
	output logic resp_valid,
	input logic resp_ready,
	output paddr_t resp_paddr,
	output logic resp_fault,
	input word_addr_t ptbr,
	input logic flush,
	input logic host_valid,
	output logic host_ready,
	input word_addr_t host_addr,
	input pte_t host_wdata
);

	logic walk_valid;
	logic walk_ready;
	vpn_t walk_vpn;
	logic walk_done;
	ppn_t walk_ppn;
	logic walk_fault;

	logic pw_m_valid;
	logic pw_m_ready;
	word_addr_t pw_m_addr;
	logic pw_m_rvalid;
	pte_t pw_m_rdata;

	logic mem_en;
	logic mem_we;
	word_addr_t mem_addr;
	pte_t mem_wdata;
	pte_t mem_rdata;

	tlb u_tlb (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_ready(req_ready), .req_vaddr(req_vaddr),
		.resp_valid(resp_valid), .resp_ready(resp_ready),
		.resp_paddr(resp_paddr), .resp_fault(resp_fault),
		.flush(flush),
		.walk_valid(walk_valid), .walk_ready(walk_ready), .walk_vpn(walk_vpn),
		.walk_done(walk_done), .walk_ppn(walk_ppn), .walk_fault(walk_fault)
	);

	page_walker u_walker (
		.clk(clk), .reset(reset),
		.walk_valid(walk_valid), .walk_ready(walk_ready), .walk_vpn(walk_vpn),
		.walk_done(walk_done), .walk_ppn(walk_ppn), .walk_fault(walk_fault),
		.ptbr(ptbr),
		.m_valid(pw_m_valid), .m_ready(pw_m_ready), .m_addr(pw_m_addr),
		.m_rvalid(pw_m_rvalid), .m_rdata(pw_m_rdata)
	);

	mem_arbiter u_arb (
		.clk(clk), .reset(reset),
		.w_valid(pw_m_valid), .w_ready(pw_m_ready), .w_addr(pw_m_addr),
		.w_rvalid(pw_m_rvalid), .w_rdata(pw_m_rdata),
		.h_valid(host_valid), .h_ready(host_ready), .h_we(1'b1), // host only writes
		.h_addr(host_addr), .h_wdata(host_wdata),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	phys_mem u_mem (
		.clk(clk),
		.mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

endmodule

//--- test/tb_tasks.svh
// drives the DUT ports of tb_mmu directly; tasks start and end 1 ns after a rising edge
`ifndef tb_tasks_svh
`define tb_tasks_svh

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

task automatic next_offset(output logic [page_offset_bits-1:0] off);
	rng = xorshift(rng);
	off = rng[page_offset_bits-1:0];
endtask

task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("Fail %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
	end
endtask

function automatic pte_t make_pte(input ppn_t ppn, input logic valid);
	pte_t p;
	p = '0;
	p[pte_ppn_lsb +: ppn_bits] = ppn;
	p[pte_valid_bit] = valid;
	return p;
endfunction

task automatic host_write(input word_addr_t addr, input pte_t data);
	logic granted;
	host_valid = 1'b1;
	host_addr = addr;
	host_wdata = data;
	granted = 1'b0;
	while (!granted) begin
		@(negedge clk);
		granted = host_ready; // sampled mid-cycle, the edge sees the same
		@(posedge clk);
		#1;
	end
	host_valid = 1'b0;
	table_model[addr] = data;
endtask

// two-level lookup in the testbench copy of the tables
task automatic walk_model(input vaddr_t va, output paddr_t pa, output logic fault);
	vpn_t vpn;
	pte_t l1;
	pte_t l2;
	word_addr_t l2_base;
	vpn = va[vaddr_bits-1:page_offset_bits];
	l1 = table_model[ptbr + word_addr_t'(vpn[vpn_bits-1 -: level_bits])];
	pa = '0;
	fault = 1'b1;
	if (l1[pte_valid_bit]) begin
		l2_base = l1[pte_ppn_lsb +: $bits(word_addr_t)];
		l2 = table_model[l2_base + word_addr_t'(vpn[level_bits-1:0])];
		fault = !l2[pte_valid_bit];
		pa = {l2[pte_ppn_lsb +: ppn_bits], va[page_offset_bits-1:0]};
	end
endtask

// hold > 0 keeps resp_ready low for that many cycles after resp_valid
task automatic translate(input string name, input vaddr_t va, input int hold,
	output paddr_t pa, output logic fault, output int lat);
	logic accepted;
	req_valid = 1'b1;
	req_vaddr = va;
	resp_ready = (hold == 0);
	accepted = 1'b0;
	while (!accepted) begin
		@(negedge clk);
		accepted = req_ready;
		@(posedge clk);
		#1;
	end
	req_valid = 1'b0;
	lat = 0;
	@(negedge clk);
	while (!resp_valid) begin
		@(negedge clk);
		lat++; // edges since acceptance
	end
	pa = resp_paddr;
	fault = resp_fault;
	if (hold > 0) begin
		repeat (hold) begin
			@(negedge clk);
			check({name, " held resp_valid"}, 64'd1, 64'(resp_valid));
			check({name, " held paddr"}, 64'(pa), 64'(resp_paddr));
			check({name, " held fault"}, 64'(fault), 64'(resp_fault));
			check({name, " held req_ready"}, 64'd0, 64'(req_ready));
		end
		@(posedge clk);
		#1;
		resp_ready = 1'b1;
	end
	@(posedge clk); // transfer edge
	#1;
	check({name, " resp_valid after transfer"}, 64'd0, 64'(resp_valid));
endtask

`endif

//--- test/tb_mmu.sv
// page tables sit at ptbr = 0 with level-two tables at words 128 and 192; host port only writes
`timescale 1ns/1ps

module tb_mmu import mmu_pkg::*; ();

	localparam int clk_period = 40;
	localparam int reset_cycles = 10;
	localparam int max_translations = 24;
	localparam int max_writes = 24;
	localparam int cycles_per_translation = 20;
	localparam int cycles_per_write = 4;
	localparam word_addr_t l2_base_a = 10'd128;
	localparam word_addr_t l2_base_b = 10'd192;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_ready;
	vaddr_t req_vaddr;
	logic resp_valid;
	logic resp_ready;
	paddr_t resp_paddr;
	logic resp_fault;
	word_addr_t ptbr;
	logic flush;
	logic host_valid;
	logic host_ready;
	word_addr_t host_addr;
	pte_t host_wdata;

	pte_t table_model [mem_words];
	logic [31:0] rng;
	int checks;
	int errors;

	mmu_top uut (
		.clk(clk), .reset(reset),
		.req_valid(req_valid), .req_ready(req_ready), .req_vaddr(req_vaddr),
		.resp_valid(resp_valid), .resp_ready(resp_ready),
		.resp_paddr(resp_paddr), .resp_fault(resp_fault),
		.ptbr(ptbr), .flush(flush),
		.host_valid(host_valid), .host_ready(host_ready),
		.host_addr(host_addr), .host_wdata(host_wdata)
	);

	`include "tb_tasks.svh"

	always #(clk_period / 2) clk = ~clk;

	function automatic vaddr_t page_va(input int l1, input int l2,
		input logic [page_offset_bits-1:0] off);
		return {6'(l1), 6'(l2), off};
	endfunction

	task automatic expect_translation(input string name, input vaddr_t va, input int hold,
		input paddr_t exp_pa, input logic exp_fault, output int lat);
		paddr_t pa;
		logic fault;
		translate(name, va, hold, pa, fault, lat);
		check({name, " fault"}, 64'(exp_fault), 64'(fault));
		if (!exp_fault)
			check({name, " paddr"}, 64'(exp_pa), 64'(pa));
	endtask

	task automatic expect_from_model(input string name, input vaddr_t va, input int hold,
		output int lat);
		paddr_t exp_pa;
		logic exp_fault;
		walk_model(va, exp_pa, exp_fault);
		expect_translation(name, va, hold, exp_pa, exp_fault, lat);
	endtask

	task automatic test_miss_walk();
		logic [page_offset_bits-1:0] off;
		int lat;
		host_write(ptbr + 10'd1, make_pte(ppn_t'(l2_base_a), 1'b1));
		for (int i = 0; i < 4; i++)
			host_write(l2_base_a + word_addr_t'(i), make_pte(ppn_t'(i) + 20'h12340, 1'b1));
		for (int i = 0; i < 4; i++) begin
			next_offset(off);
			expect_from_model("miss walk", page_va(1, i, off), 0, lat);
			check("miss walk latency", 64'd1, 64'(lat >= 5)); // lookup plus walk of 4
		end
	endtask

	task automatic test_hit_timing();
		logic [page_offset_bits-1:0] off;
		int lat;
		next_offset(off);
		expect_from_model("hit timing", page_va(1, 1, off), 0, lat);
		check("hit timing latency", 64'd1, 64'(lat));
	endtask

	task automatic test_faults();
		logic [page_offset_bits-1:0] off;
		int lat;
		host_write(ptbr + 10'd2, '0);
		host_write(l2_base_a + 10'd10, '0);
		next_offset(off);
		expect_translation("l1 fault", page_va(2, 5, off), 0, '0, 1'b1, lat);
		next_offset(off);
		expect_translation("l2 fault", page_va(1, 10, off), 0, '0, 1'b1, lat);
		host_write(ptbr + 10'd2, make_pte(ppn_t'(l2_base_b), 1'b1));
		host_write(l2_base_b + 10'd5, make_pte(20'h0abcd, 1'b1));
		host_write(l2_base_a + 10'd10, make_pte(20'h5a5a5, 1'b1));
		next_offset(off);
		expect_from_model("l1 fault remapped", page_va(2, 5, off), 0, lat);
		next_offset(off);
		expect_from_model("l2 fault remapped", page_va(1, 10, off), 0, lat);
	endtask

	// pages 7, 23 and 39 all land in set 7
	task automatic test_replacement();
		logic [page_offset_bits-1:0] off;
		int lat;
		host_write(l2_base_a + 10'd7, make_pte(20'h00a07, 1'b1));
		host_write(l2_base_a + 10'd23, make_pte(20'h00b17, 1'b1));
		host_write(l2_base_a + 10'd39, make_pte(20'h00c27, 1'b1));
		next_offset(off);
		expect_from_model("replace A", page_va(1, 7, off), 0, lat);
		expect_from_model("replace B", page_va(1, 23, off), 0, lat);
		expect_from_model("replace A again", page_va(1, 7, off), 0, lat);
		expect_from_model("replace C", page_va(1, 39, off), 0, lat);
		host_write(l2_base_a + 10'd7, make_pte(20'h01a07, 1'b1));
		host_write(l2_base_a + 10'd23, make_pte(20'h01b17, 1'b1));
		next_offset(off);
		expect_translation("replace A cached", page_va(1, 7, off), 0, {20'h00a07, off}, 1'b0, lat);
		expect_from_model("replace B walked", page_va(1, 23, off), 0, lat);
	endtask

	task automatic test_flush();
		logic [page_offset_bits-1:0] off;
		int lat;
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		next_offset(off);
		expect_from_model("flush A", page_va(1, 7, off), 0, lat);
		check("flush A walked", 64'd1, 64'(lat >= 5));
	endtask

	task automatic test_backpressure();
		logic [page_offset_bits-1:0] off;
		int lat;
		next_offset(off);
		expect_from_model("backpressure hit", page_va(1, 7, off), 4, lat);
		check("backpressure hit latency", 64'd1, 64'(lat));
		host_write(l2_base_a + 10'd12, make_pte(20'h7c00c, 1'b1));
		next_offset(off);
		expect_from_model("backpressure miss", page_va(1, 12, off), 5, lat);
	endtask

	initial begin
		#((reset_cycles + max_translations * cycles_per_translation
			+ max_writes * cycles_per_write + 20) * clk_period);
		$display("timeout: the tests did not finish in the expected time");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_vaddr = '0;
		resp_ready = 1'b1;
		ptbr = '0;
		flush = 1'b0;
		host_valid = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		rng = 32'd65;
		checks = 0;
		errors = 0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		check("reset req_ready", 64'd1, 64'(req_ready));
		check("reset resp_valid", 64'd0, 64'(resp_valid));
		test_miss_walk();
		test_hit_timing();
		test_faults();
		test_replacement();
		test_flush();
		test_backpressure();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+test
rtl/mmu_pkg.sv
rtl/phys_mem.sv
rtl/mem_arbiter.sv
rtl/page_walker.sv
rtl/tlb.sv
rtl/mmu_top.sv
test/tb_mmu.sv

//--- Makefile
sim = obj_dir/tb_mmu_sim

.PHONY: all compile run clean

all: run

compile: $(sim)

$(sim): verilog.f $(wildcard rtl/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
	verilator --binary --timing --assert -f verilog.f --top-module tb_mmu -o tb_mmu_sim

run: compile
	./$(sim) > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
